/* logic/mem_pkg.sv */
// Memory-side types of the instruction fetch path
// Byte addresses, data words, fetch exception causes and the
// answer bundle returned by the instruction memory

package mem_pkg;

  // Architectural widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;

  // ------------------------------------------------------------------
  // Plain vector types
  // ------------------------------------------------------------------

  // Byte address as presented to the memory
  typedef logic [ADDR_W-1:0] addr_t;

  // One memory data word
  typedef logic [WORD_W-1:0] word_t;

  // ------------------------------------------------------------------
  // Exceptions and answers
  // ------------------------------------------------------------------

  // Fetch exception causes
  typedef enum logic [1:0] {
    EXC_NONE               = 2'd0,
    EXC_INSTR_MISALIGNED   = 2'd1,
    EXC_INSTR_ACCESS_FAULT = 2'd2
  } except_code_t;

  // Memory answer, data is zero when a fault is raised
  typedef struct packed {
    word_t        data;
    logic         except_raised;
    except_code_t except_code;
  } mem_ans_t;

endpackage

/* logic/fetch_pkg.sv */
// Fetch-side types of the instruction fetch path
// Instruction word, branch prediction record and the bundle that
// leaves the fetch stage toward issue

package fetch_pkg;

  import mem_pkg::*;

  // Instruction length, no compressed instructions
  localparam int unsigned ILEN = 32;

  // ------------------------------------------------------------------
  // Instruction and prediction
  // ------------------------------------------------------------------

  // Raw instruction word
  typedef logic [ILEN-1:0] instr_t;

  // PC under fetch and what the BTB said about it
  typedef struct packed {
    addr_t pc;
    logic  taken;
    // Next PC, BTB target on a hit, PC plus 4 otherwise
    addr_t target;
  } prediction_t;

  // ------------------------------------------------------------------
  // Issue side
  // ------------------------------------------------------------------

  // Answer register contents, also the issue output
  typedef struct packed {
    instr_t       instr;
    prediction_t  pred;
    logic         except_raised;
    except_code_t except_code;
  } issue_bundle_t;

endpackage

/* logic/spill_cell.sv */
// Spill cell
// Two-entry valid/ready register slice with flush. The upstream
// ready only looks at the spill register, so no combinational path
// runs from ready_i back to ready_o

module spill_cell #(
  parameter type DATA_T = logic [31:0]
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,
  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  logic  main_valid_q, spill_valid_q;
  DATA_T main_data_q, spill_data_q;
  logic  in_xfer, out_xfer;
  logic  main_load_in, main_from_spill, spill_load;

  // Handshake decode
  assign in_xfer  = valid_i & ~spill_valid_q;
  assign out_xfer = main_valid_q & ready_i;

  // Main takes new data when empty or draining without a spilled item
  assign main_load_in    = in_xfer & (~main_valid_q | out_xfer);
  assign main_from_spill = out_xfer & spill_valid_q;
  // Park incoming data when main is held
  assign spill_load      = in_xfer & main_valid_q & ~out_xfer;

  // Occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
    end else begin
      if (main_from_spill || main_load_in) begin
        main_valid_q <= 1'b1;
      end else if (out_xfer) begin
        main_valid_q <= 1'b0;
      end
      if (spill_load) begin
        spill_valid_q <= 1'b1;
      end else if (main_from_spill) begin
        spill_valid_q <= 1'b0;
      end
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (main_from_spill) begin
      main_data_q <= spill_data_q;
    end else if (main_load_in) begin
      main_data_q <= data_i;
    end
    if (spill_load) begin
      spill_data_q <= data_i;
    end
  end

  assign ready_o = ~spill_valid_q;
  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;

endmodule

/* logic/pred_fifo.sv */
// Prediction FIFO
// Circular buffer without handshake. The owner guarantees that it
// never pushes a full FIFO, unless it pops in the same cycle

module pred_fifo #(
  parameter type DATA_T          = logic [31:0],
  parameter int  MAX_OUTSTANDING = 2
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  flush_i,
  input  logic  push_i,
  input  logic  pop_i,
  input  DATA_T data_i,
  output DATA_T data_o,
  output logic  full_o
);

  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  DATA_T buf_q [MAX_OUTSTANDING];
  ptr_t  rd_ptr_q, wr_ptr_q;
  cnt_t  count_q;

  // Pointer and count update
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Wrap by hand, depth need not be a power of two
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      buf_q[wr_ptr_q] <= data_i;
    end
  end

  // Oldest entry always on the output
  assign data_o = buf_q[rd_ptr_q];
  assign full_o = (count_q == cnt_t'(MAX_OUTSTANDING));

endmodule

/* logic/pc_gen.sv */
// PC generator
// Holds the fetch PC and a four-entry direct-mapped BTB. Produces one
// prediction per fetch; a redirect restarts the PC and trains the BTB

module pc_gen
  import mem_pkg::*;
  import fetch_pkg::*;
#(
  parameter addr_t BOOT_PC = '0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  // Redirect from outside
  input  logic        redirect_i,
  input  addr_t       redirect_from_i,
  input  addr_t       redirect_to_i,
  // Fetch link
  output logic        fetch_valid_o,
  input  logic        fetch_ready_i,
  output prediction_t fetch_pred_o
);

  localparam int unsigned BTB_ENTRIES = 4;

  // Index is PC bits 3:2, tag the bits above
  typedef logic [1:0]  btb_idx_t;
  typedef logic [27:0] btb_tag_t;

  typedef struct packed {
    logic     valid;
    btb_tag_t tag;
    addr_t    target;
  } btb_entry_t;

  addr_t      pc_q;
  logic       valid_q;
  btb_entry_t btb_q [BTB_ENTRIES];
  btb_idx_t   lookup_idx, train_idx;
  btb_tag_t   lookup_tag;
  logic       btb_hit;
  logic       fetch_xfer;

  // ------------------------------------------------------------------
  // BTB lookup
  // ------------------------------------------------------------------
  assign lookup_idx = pc_q[3:2];
  assign lookup_tag = pc_q[31:4];
  assign btb_hit    = btb_q[lookup_idx].valid && (btb_q[lookup_idx].tag == lookup_tag);

  assign fetch_pred_o.pc     = pc_q;
  assign fetch_pred_o.taken  = btb_hit;
  assign fetch_pred_o.target = btb_hit ? btb_q[lookup_idx].target : pc_q + addr_t'(4);

  assign fetch_valid_o = valid_q;
  assign fetch_xfer    = valid_q & fetch_ready_i;

  // ------------------------------------------------------------------
  // PC register
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q    <= BOOT_PC;
      valid_q <= 1'b0;
    end else begin
      // Always fetching once out of reset
      valid_q <= 1'b1;
      if (redirect_i) begin
        pc_q <= redirect_to_i;
      end else if (fetch_xfer) begin
        pc_q <= fetch_pred_o.target;
      end
    end
  end

  // ------------------------------------------------------------------
  // BTB training
  // ------------------------------------------------------------------
  assign train_idx = redirect_from_i[3:2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        btb_q[i].valid <= 1'b0;
      end
    end else if (redirect_i) begin
      btb_q[train_idx].valid  <= 1'b1;
      btb_q[train_idx].tag    <= redirect_from_i[31:4];
      btb_q[train_idx].target <= redirect_to_i;
    end
  end

endmodule

/* logic/fetch_mem_if.sv */
// Fetch memory interface
// Registers fetch requests toward the instruction memory, parks each
// prediction in a FIFO while the memory works and joins the in-order
// answer with its prediction in a register toward issue

module fetch_mem_if
  import mem_pkg::*;
  import fetch_pkg::*;
#(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          flush_i,
  // PC generator
  input  logic          fetch_valid_i,
  output logic          fetch_ready_o,
  input  prediction_t   fetch_pred_i,
  // Memory request
  output logic          mem_req_valid_o,
  input  logic          mem_req_ready_i,
  output addr_t         mem_req_addr_o,
  // Memory answer
  input  logic          mem_ans_valid_i,
  output logic          mem_ans_ready_o,
  input  mem_ans_t      mem_ans_i,
  // Issue stage
  output logic          issue_valid_o,
  input  logic          issue_ready_i,
  output issue_bundle_t issue_o
);

  prediction_t   req_reg_out;
  logic          req_reg_valid, req_reg_ready;
  logic          pred_push, pred_pop;
  logic          pred_full, req_block;
  prediction_t   pred_fifo_out;
  issue_bundle_t ans_reg_in;

  // ------------------------------------------------------------------
  // Request register
  // ------------------------------------------------------------------
  spill_cell #(
    .DATA_T (prediction_t)
  ) u_req_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (fetch_valid_i),
    .ready_o (fetch_ready_o),
    .data_i  (fetch_pred_i),
    .valid_o (req_reg_valid),
    .ready_i (req_reg_ready),
    .data_o  (req_reg_out)
  );

  // Hold requests while the FIFO is full, unless an answer frees a slot
  assign req_block       = pred_full & ~pred_pop;
  assign mem_req_valid_o = req_reg_valid & ~req_block;
  assign req_reg_ready   = mem_req_ready_i & ~req_block;
  assign mem_req_addr_o  = req_reg_out.pc;

  // ------------------------------------------------------------------
  // Prediction FIFO
  // ------------------------------------------------------------------
  // Memory answers in order, so the oldest entry matches each answer
  assign pred_push = mem_req_valid_o & mem_req_ready_i;
  assign pred_pop  = mem_ans_valid_i & mem_ans_ready_o;

  pred_fifo #(
    .DATA_T          (prediction_t),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_pred_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .push_i  (pred_push),
    .pop_i   (pred_pop),
    .data_i  (req_reg_out),
    .data_o  (pred_fifo_out),
    .full_o  (pred_full)
  );

  // ------------------------------------------------------------------
  // Answer register
  // ------------------------------------------------------------------
  assign ans_reg_in.instr         = instr_t'(mem_ans_i.data);
  assign ans_reg_in.pred          = pred_fifo_out;
  assign ans_reg_in.except_raised = mem_ans_i.except_raised;
  assign ans_reg_in.except_code   = mem_ans_i.except_code;

  spill_cell #(
    .DATA_T (issue_bundle_t)
  ) u_ans_reg (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .valid_i (mem_ans_valid_i),
    .ready_o (mem_ans_ready_o),
    .data_i  (ans_reg_in),
    .valid_o (issue_valid_o),
    .ready_i (issue_ready_i),
    .data_o  (issue_o)
  );

endmodule

/* logic/instr_mem.sv */
// Instruction memory
// Word array filled through a loader port and read through an in-order
// pipeline of fixed depth that freezes while its output is stalled.
// Flags misaligned and out-of-range fetch addresses

module instr_mem
  import mem_pkg::*;
#(
  parameter int MEM_WORDS   = 64,
  parameter int MEM_LATENCY = 2
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     flush_i,
  // Request link
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  addr_t    req_addr_i,
  // Answer link
  output logic     ans_valid_o,
  input  logic     ans_ready_i,
  output mem_ans_t ans_o,
  // Loader
  input  logic     load_we_i,
  input  addr_t    load_addr_i,
  input  word_t    load_data_i
);

  localparam int    IDX_W     = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam addr_t MEM_BYTES = addr_t'(4 * MEM_WORDS);

  word_t    mem_q [MEM_WORDS];
  logic     stage_valid_q [MEM_LATENCY];
  mem_ans_t stage_ans_q [MEM_LATENCY];
  mem_ans_t req_ans;
  logic     advance;

  // Loader write port
  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem_q[load_addr_i[IDX_W+1:2]] <= load_data_i;
    end
  end

  // ------------------------------------------------------------------
  // Read and fault check
  // ------------------------------------------------------------------
  always_comb begin
    req_ans = '{data: '0, except_raised: 1'b0, except_code: EXC_NONE};
    // Misalignment wins over range
    if (req_addr_i[1:0] != 2'b00) begin
      req_ans.except_raised = 1'b1;
      req_ans.except_code   = EXC_INSTR_MISALIGNED;
    end else if (req_addr_i >= MEM_BYTES) begin
      req_ans.except_raised = 1'b1;
      req_ans.except_code   = EXC_INSTR_ACCESS_FAULT;
    end else begin
      req_ans.data = mem_q[req_addr_i[IDX_W+1:2]];
    end
  end

  // ------------------------------------------------------------------
  // Read pipeline
  // ------------------------------------------------------------------
  // Whole pipe moves only when the last stage is empty or taken
  assign advance     = ~stage_valid_q[MEM_LATENCY-1] | ans_ready_i;
  assign req_ready_o = advance;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      for (int i = 0; i < MEM_LATENCY; i++) begin
        stage_valid_q[i] <= 1'b0;
      end
    end else if (advance) begin
      stage_valid_q[0] <= req_valid_i;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        stage_valid_q[i] <= stage_valid_q[i-1];
      end
    end
  end

  // Answer payload follows the valid bits
  always_ff @(posedge clk_i) begin
    if (advance) begin
      stage_ans_q[0] <= req_ans;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        stage_ans_q[i] <= stage_ans_q[i-1];
      end
    end
  end

  assign ans_valid_o = stage_valid_q[MEM_LATENCY-1];
  assign ans_o       = stage_ans_q[MEM_LATENCY-1];

endmodule

/* logic/fetch_top.sv */
// Instruction fetch front end
// PC generator, fetch memory interface and instruction memory, with
// the issue, redirect and loader ports brought out

module fetch_top
  import mem_pkg::*;
  import fetch_pkg::*;
#(
  parameter addr_t BOOT_PC         = '0,
  parameter int    MAX_OUTSTANDING = 2,
  parameter int    MEM_WORDS       = 64,
  parameter int    MEM_LATENCY     = 2
) (
  input  logic          clk_i,
  input  logic          rst_i,
  // Redirect pulse, also flushes the pipeline
  input  logic          redirect_valid_i,
  input  addr_t         redirect_from_i,
  input  addr_t         redirect_to_i,
  // Loader
  input  logic          load_we_i,
  input  addr_t         load_addr_i,
  input  word_t         load_data_i,
  // Issue
  output logic          issue_valid_o,
  input  logic          issue_ready_i,
  output issue_bundle_t issue_o
);

  logic        fetch_valid, fetch_ready;
  prediction_t fetch_pred;
  logic        mem_req_valid, mem_req_ready;
  addr_t       mem_req_addr;
  logic        mem_ans_valid, mem_ans_ready;
  mem_ans_t    mem_ans;

  // ------------------------------------------------------------------
  // PC generation
  // ------------------------------------------------------------------
  pc_gen #(
    .BOOT_PC (BOOT_PC)
  ) u_pc_gen (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .redirect_i      (redirect_valid_i),
    .redirect_from_i (redirect_from_i),
    .redirect_to_i   (redirect_to_i),
    .fetch_valid_o   (fetch_valid),
    .fetch_ready_i   (fetch_ready),
    .fetch_pred_o    (fetch_pred)
  );

  // ------------------------------------------------------------------
  // Memory interface
  // ------------------------------------------------------------------
  fetch_mem_if #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_fetch_mem_if (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .flush_i         (redirect_valid_i),
    .fetch_valid_i   (fetch_valid),
    .fetch_ready_o   (fetch_ready),
    .fetch_pred_i    (fetch_pred),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_req_addr_o  (mem_req_addr),
    .mem_ans_valid_i (mem_ans_valid),
    .mem_ans_ready_o (mem_ans_ready),
    .mem_ans_i       (mem_ans),
    .issue_valid_o   (issue_valid_o),
    .issue_ready_i   (issue_ready_i),
    .issue_o         (issue_o)
  );

  // ------------------------------------------------------------------
  // Instruction memory
  // ------------------------------------------------------------------
  instr_mem #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_instr_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (redirect_valid_i),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .req_addr_i  (mem_req_addr),
    .ans_valid_o (mem_ans_valid),
    .ans_ready_i (mem_ans_ready),
    .ans_o       (mem_ans),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

/* bench/tb_fetch.sv */
// Testbench for the instruction fetch front end
// Preloads the memory through the loader, then runs directed tests
// against a reference model of the PC and BTB rules

module tb_fetch
  import mem_pkg::*;
  import fetch_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int MEM_WORDS    = 64;
  localparam int MEM_LATENCY  = 2;
  // Longest wait for one issue transfer
  localparam int ITEM_TIMEOUT = 40;
  // Issued items per test
  localparam int N_SEQ        = 12;
  localparam int N_BP         = 24;
  localparam int N_REDIRECT   = 6;
  localparam int N_BTB        = 10;
  localparam int N_FAULT      = 6;
  localparam int N_ITEMS      = N_SEQ + N_BP + N_REDIRECT + N_BTB + N_FAULT;
  // Loading, reset, a generous budget per item and a margin
  localparam int RUN_CYCLES   = MEM_WORDS + RESET_CYCLES + 8 * N_ITEMS + 200;

  logic          clk, rst;
  logic          redirect_valid;
  addr_t         redirect_from, redirect_to;
  logic          load_we;
  addr_t         load_addr;
  word_t         load_data;
  logic          issue_valid, issue_ready;
  issue_bundle_t issue_bundle;

  // Reference model state
  addr_t         exp_pc;
  logic          btb_valid [4];
  logic [27:0]   btb_tag [4];
  addr_t         btb_target [4];
  logic          saw_taken;

  int            checks, errors, test_errors, tests_run;

  fetch_top #(
    .BOOT_PC         (32'h0),
    .MAX_OUTSTANDING (2),
    .MEM_WORDS       (MEM_WORDS),
    .MEM_LATENCY     (MEM_LATENCY)
  ) uut (
    .clk_i            (clk),
    .rst_i            (rst),
    .redirect_valid_i (redirect_valid),
    .redirect_from_i  (redirect_from),
    .redirect_to_i    (redirect_to),
    .load_we_i        (load_we),
    .load_addr_i      (load_addr),
    .load_data_i      (load_data),
    .issue_valid_o    (issue_valid),
    .issue_ready_i    (issue_ready),
    .issue_o          (issue_bundle)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------

  // Memory fill mixing in every address bit
  function automatic word_t word_at(addr_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  function automatic issue_bundle_t expected_bundle(addr_t pc);
    issue_bundle_t b;
    logic [1:0]    idx;
    b   = '0;
    idx = pc[3:2];
    b.pred.pc     = pc;
    b.pred.taken  = btb_valid[idx] && (btb_tag[idx] == pc[31:4]);
    b.pred.target = b.pred.taken ? btb_target[idx] : pc + 32'd4;
    // Faults return zero data and misalignment is checked first
    if (pc[1:0] != 2'b00) begin
      b.except_raised = 1'b1;
      b.except_code   = EXC_INSTR_MISALIGNED;
    end else if (pc >= addr_t'(4 * MEM_WORDS)) begin
      b.except_raised = 1'b1;
      b.except_code   = EXC_INSTR_ACCESS_FAULT;
    end else begin
      b.instr = word_at(pc);
    end
    return b;
  endfunction

  task automatic clear_model();
    for (int i = 0; i < 4; i++) begin
      btb_valid[i] = 1'b0;
    end
    exp_pc = 32'h0;
  endtask

  // Redirect restarts the PC and writes one BTB entry
  task automatic train_btb_model(input addr_t from_pc, input addr_t to_pc);
    logic [1:0] idx;
    idx = from_pc[3:2];
    btb_valid[idx]  = 1'b1;
    btb_tag[idx]    = from_pc[31:4];
    btb_target[idx] = to_pc;
    exp_pc          = to_pc;
  endtask

  // --------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------
  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      test_errors++;
      $display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic compare_bundle(input issue_bundle_t got, input issue_bundle_t expected);
    string where;
    where = $sformatf("pc %h", expected.pred.pc);
    check_value({where, " issued pc"}, 128'(got.pred.pc), 128'(expected.pred.pc));
    check_value({where, " prediction"}, 128'(got.pred), 128'(expected.pred));
    check_value({where, " instruction"}, 128'(got.instr), 128'(expected.instr));
    check_value({where, " exception"}, 128'({got.except_raised, got.except_code}),
                128'({expected.except_raised, expected.except_code}));
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("Test %-18s done, %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  // --------------------------------------------------------------------
  // Stimulus helpers entered and left 1 unit after a rising edge
  // --------------------------------------------------------------------
  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      load_we   = 1'b1;
      load_addr = addr_t'(4 * i);
      load_data = word_at(addr_t'(4 * i));
      @(posedge clk);
      #1;
    end
    load_we = 1'b0;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    clear_model();
  endtask

  // Issue side held off so nothing transfers in the flush cycle
  task automatic send_redirect(input addr_t from_pc, input addr_t to_pc);
    issue_ready    = 1'b0;
    redirect_valid = 1'b1;
    redirect_from  = from_pc;
    redirect_to    = to_pc;
    @(posedge clk);
    #1;
    redirect_valid = 1'b0;
    train_btb_model(from_pc, to_pc);
  endtask

  // Takes count issue transfers and checks each against the model
  task automatic collect_issue(input int count, input logic random_ready);
    issue_bundle_t exp_b, held;
    logic          stalled;
    int            got_items, idle;
    got_items = 0;
    idle      = 0;
    stalled   = 1'b0;
    held      = '0;
    while (got_items < count && idle < ITEM_TIMEOUT) begin
      issue_ready = random_ready ? 1'($urandom & 32'd1) : 1'b1;
      // Stalled output must not move
      if (stalled) begin
        check_value("valid held while stalled", 128'(issue_valid), 128'(1'b1));
        check_value("bundle held while stalled", 128'(issue_bundle), 128'(held));
      end
      if (issue_valid && issue_ready) begin
        exp_b = expected_bundle(exp_pc);
        compare_bundle(issue_bundle, exp_b);
        if (issue_bundle.pred.taken) begin
          saw_taken = 1'b1;
        end
        exp_pc = exp_b.pred.target;
        got_items++;
        idle    = 0;
        stalled = 1'b0;
      end else begin
        idle++;
        stalled = issue_valid;
        held    = issue_bundle;
      end
      @(posedge clk);
      #1;
    end
    issue_ready = 1'b0;
    if (got_items < count) begin
      errors++;
      test_errors++;
      $display("No issue for %0d cycles, only %0d of %0d items seen",
               ITEM_TIMEOUT, got_items, count);
    end
  endtask

  // --------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------
  task automatic sequential_fetch();
    int wait_cycles;
    wait_cycles = 0;
    // PC generator raises fetch valid on this edge
    @(posedge clk);
    #1;
    while (!issue_valid && wait_cycles < ITEM_TIMEOUT) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end
    check_value("cycles from first fetch to issue", 128'(wait_cycles),
                128'(MEM_LATENCY + 2));
    collect_issue(N_SEQ, 1'b0);
    report_test("sequential fetch");
  endtask

  task automatic back_pressure();
    collect_issue(N_BP, 1'b1);
    report_test("back-pressure");
  endtask

  // BTB entry 0 written with a tag that no fetch here reaches
  task automatic redirect_flush();
    send_redirect(32'h200, 32'h20);
    collect_issue(N_REDIRECT, 1'b0);
    report_test("redirect");
  endtask

  task automatic btb_training();
    saw_taken = 1'b0;
    send_redirect(32'h28, 32'h10);
    collect_issue(N_BTB, 1'b0);
    check_value("taken prediction seen", 128'(saw_taken), 128'(1'b1));
    report_test("BTB training");
  endtask

  task automatic fetch_faults();
    send_redirect(32'h300, 32'h102);
    collect_issue(N_FAULT / 2, 1'b0);
    // 0x100 is the first byte past 64 words
    send_redirect(32'h304, 32'h100);
    collect_issue(N_FAULT / 2, 1'b0);
    report_test("faults");
  endtask

  // --------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------
  initial begin
    void'($urandom(32'h49e0_9501));
    rst            = 1'b1;
    redirect_valid = 1'b0;
    redirect_from  = '0;
    redirect_to    = '0;
    load_we        = 1'b0;
    load_addr      = '0;
    load_data      = '0;
    issue_ready    = 1'b0;
    checks         = 0;
    errors         = 0;
    test_errors    = 0;
    tests_run      = 0;
    saw_taken      = 1'b0;
    clear_model();
    @(posedge clk);
    #1;
    // Memory filled while the core is held in reset
    load_memory();
    apply_reset();
    sequential_fetch();
    back_pressure();
    redirect_flush();
    btb_training();
    fetch_faults();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, tests did not complete", RUN_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule

/* src.f */
logic/mem_pkg.sv
logic/fetch_pkg.sv
logic/spill_cell.sv
logic/pred_fifo.sv
logic/pc_gen.sv
logic/fetch_mem_if.sv
logic/instr_mem.sv
logic/fetch_top.sv
bench/tb_fetch.sv

/* Makefile */
# Verilator build and regression for the instruction fetch front end

VERILATOR  ?= verilator
TOP        := tb_fetch
FILE_LIST  := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# Output is kept in a shell variable and searched for the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
